//--- Bender.yml
package:
  name: fxp_unit

sources:
  - files:
      - rtl/fxp_num_pkg.sv
      - rtl/fxp_op_pkg.sv
      - rtl/subfxp.sv
      - rtl/addfxp.sv
      - rtl/multfxp.sv
      - rtl/fxp_delay_line.sv
      - rtl/fxp_result_select.sv
      - rtl/fxp_unit.sv
  - target: simulation
    files:
      - dv/fxp_unit_checker.sv
      - dv/fxp_unit_tb.sv

//--- dv/fxp_unit_checker.sv
// Fixed-point unit checker
// Reference model, expected queue and comparison

`timescale 1ns/1ps

module fxp_unit_checker #(
  parameter int cycles = 1,
  parameter int frac   = fxp_num_pkg::FRAC
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_valid,
  input  fxp_op_pkg::cmd_t cmd,
  input  logic             out_valid,
  input  fxp_op_pkg::rsp_t rsp,
  output int               error_count,
  output int               check_count,
  output int               pending
);

  localparam int WIDTH = fxp_num_pkg::WIDTH;

  fxp_op_pkg::rsp_t exp_q [$];
  int               issue_q [$];
  int               cyc;
  logic             reset_seen;

  // Expected response from the result rules
  function automatic fxp_op_pkg::rsp_t reference_rsp(input fxp_op_pkg::cmd_t c);
    fxp_op_pkg::rsp_t r;
    logic [WIDTH-1:0] raw;
    longint           prod;
    longint           max_val;
    longint           min_val;
    max_val = (longint'(1) <<< (WIDTH - 1)) - 1;
    min_val = -(longint'(1) <<< (WIDTH - 1));
    r.tag   = c.tag;
    r.ovf   = 1'b0;
    case (c.op)
      fxp_op_pkg::OP_ADD: begin
        // Wrapped to WIDTH bits, unsigned so the shift is logical
        raw     = c.a + c.b;
        r.value = raw >> (cycles - 1);
      end
      fxp_op_pkg::OP_SUB: begin
        raw     = c.a - c.b;
        r.value = raw >> (cycles - 1);
      end
      fxp_op_pkg::OP_MUL: begin
        prod = longint'(c.a) * longint'(c.b);
        prod = prod >>> frac;
        if (prod > max_val) begin
          r.value = max_val[WIDTH-1:0];
          r.ovf   = 1'b1;
        end else if (prod < min_val) begin
          r.value = min_val[WIDTH-1:0];
          r.ovf   = 1'b1;
        end else begin
          r.value = prod[WIDTH-1:0];
        end
      end
      default: begin
        r.value = c.a;
      end
    endcase
    return r;
  endfunction

  task automatic compare_response();
    fxp_op_pkg::rsp_t exp_rsp;
    int               issued;
    if (exp_q.size() == 0) begin
      error_count++;
      $display("%0t: response with tag 0x%h appeared with no command in flight",
               $time, rsp.tag);
    end else begin
      exp_rsp = exp_q.pop_front();
      issued  = issue_q.pop_front();
      check_count++;
      if (cyc - issued != cycles + 1) begin
        error_count++;
        $display("%0t: response arrived %0d cycles after its command instead of %0d",
                 $time, cyc - issued, cycles + 1);
      end
      if (rsp.tag !== exp_rsp.tag) begin
        error_count++;
        $display("[ERROR] tag expected 0x%h actual 0x%h", exp_rsp.tag, rsp.tag);
      end
      if (rsp.value !== exp_rsp.value) begin
        error_count++;
        $display("[ERROR] value expected 0x%h actual 0x%h", exp_rsp.value, rsp.value);
      end
      if (rsp.ovf !== exp_rsp.ovf) begin
        error_count++;
        $display("[ERROR] ovf expected 0x%h actual 0x%h", exp_rsp.ovf, rsp.ovf);
      end
    end
  endtask

  initial begin
    error_count = 0;
    check_count = 0;
    pending     = 0;
    cyc         = 0;
    reset_seen  = 1'b0;
  end

  // Falling edge, inputs are settled for the next rising edge
  // Outputs hold what the previous rising edge produced
  always @(negedge clk) begin
    cyc++;
    if (reset_seen && out_valid !== 1'b0 && out_valid !== 1'b1) begin
      error_count++;
      $display("%0t: out_valid is unknown after reset", $time);
    end else if (out_valid === 1'b1) begin
      compare_response();
    end
    // Reset at the next edge drops everything still in flight
    if (reset === 1'b1) begin
      exp_q.delete();
      issue_q.delete();
      reset_seen = 1'b1;
    end else if (in_valid === 1'b1) begin
      exp_q.push_back(reference_rsp(cmd));
      issue_q.push_back(cyc);
    end
    pending = exp_q.size();
  end

endmodule

//--- dv/fxp_unit_tb.sv
// Fixed-point unit testbench
// Clock, reset, stimulus and run limit

`timescale 1ns/1ps

module fxp_unit_tb;

  localparam int CYCLES    = 3;
  localparam int LAT       = CYCLES + 1;
  localparam int NUM_TESTS = 6;

  // Stimulus length of each test in cycles
  localparam int LEN_RESET  = 18;
  localparam int LEN_ADDSUB = 10;
  localparam int LEN_MUL    = 6;
  localparam int LEN_PASS   = 4;
  // 400 commands, worst case one idle gap before each
  localparam int LEN_STREAM = 800;
  localparam int LEN_MIDRST = 38;
  localparam int TIMEOUT    = LEN_RESET + LEN_ADDSUB + LEN_MUL + LEN_PASS + LEN_STREAM
                              + LEN_MIDRST + LAT * NUM_TESTS + 100;

  logic             clk;
  logic             reset;
  logic             in_valid;
  fxp_op_pkg::cmd_t cmd;
  logic             out_valid;
  fxp_op_pkg::rsp_t rsp;

  int          error_count;
  int          check_count;
  int          pending;
  logic [31:0] rng;
  int          tests_run;
  int          tests_passed;
  int          errors_at_start;
  int          cycle_cnt;
  string       test_name;

  fxp_unit #(
    .width  (fxp_num_pkg::WIDTH),
    .cycles (CYCLES),
    .frac   (fxp_num_pkg::FRAC)
  ) uut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .cmd       (cmd),
    .out_valid (out_valid),
    .rsp       (rsp)
  );

  // Watches the same ports and does all the comparing
  fxp_unit_checker #(
    .cycles (CYCLES),
    .frac   (fxp_num_pkg::FRAC)
  ) u_check (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .cmd         (cmd),
    .out_valid   (out_valid),
    .rsp         (rsp),
    .error_count (error_count),
    .check_count (check_count),
    .pending     (pending)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_random(output logic [31:0] r);
    rng = xorshift32(rng);
    r   = rng;
  endtask

  // Full random command, any op, tag and operands
  task automatic random_cmd(output fxp_op_pkg::cmd_t c);
    logic [31:0] r0;
    logic [31:0] r1;
    next_random(r0);
    next_random(r1);
    c.op  = fxp_op_pkg::op_e'(r0[1:0]);
    c.tag = r0[5:2];
    c.a   = r0[31:16];
    c.b   = r1[31:16];
  endtask

  // Inputs change 2 ns after the rising edge
  task automatic send_cmd(input fxp_op_pkg::op_e op, input logic [3:0] tag,
                          input fxp_num_pkg::sample_t a, input fxp_num_pkg::sample_t b);
    @(posedge clk);
    #2;
    in_valid = 1'b1;
    cmd.op   = op;
    cmd.tag  = tag;
    cmd.a    = a;
    cmd.b    = b;
  endtask

  task automatic send_random();
    fxp_op_pkg::cmd_t c;
    random_cmd(c);
    send_cmd(c.op, c.tag, c.a, c.b);
  endtask

  task automatic send_idle();
    @(posedge clk);
    #2;
    in_valid = 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = error_count;
  endtask

  // Drain the pipeline, then watch a little longer for stray responses
  task automatic finish_test();
    send_idle();
    while (pending != 0) begin
      @(posedge clk);
    end
    repeat (LAT) @(posedge clk);
    tests_run++;
    if (error_count == errors_at_start) begin
      tests_passed++;
      $display("test %-10s passed", test_name);
    end else begin
      $display("test %-10s failed with %0d errors", test_name, error_count - errors_at_start);
    end
  endtask

  // Run limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("run did not finish within %0d cycles", TIMEOUT);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    reset        = 1'b1;
    in_valid     = 1'b0;
    cmd          = '0;
    rng          = 32'he80b_4d0a;
    tests_run    = 0;
    tests_passed = 0;

    // Reset held 8 cycles, then idle, no response may show
    start_test("reset");
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    repeat (10) send_idle();
    finish_test();

    // Wrapping sums, negative differences, logical shift by D
    start_test("addsub");
    send_cmd(fxp_op_pkg::OP_ADD, 4'h1, 16'h0100, 16'h0200);
    send_cmd(fxp_op_pkg::OP_ADD, 4'h2, 16'h7000, 16'h7000);
    send_cmd(fxp_op_pkg::OP_ADD, 4'h3, 16'hFFFF, 16'hFFFF);
    send_cmd(fxp_op_pkg::OP_ADD, 4'h4, 16'h8000, 16'h8000);
    send_cmd(fxp_op_pkg::OP_SUB, 4'h5, 16'h0300, 16'h0100);
    send_cmd(fxp_op_pkg::OP_SUB, 4'h6, 16'h0100, 16'h0300);
    send_cmd(fxp_op_pkg::OP_SUB, 4'h7, 16'h8000, 16'h0001);
    send_cmd(fxp_op_pkg::OP_SUB, 4'h8, 16'h0000, 16'h7FFF);
    finish_test();

    // Overflow in both directions, then exact products
    start_test("multiply");
    send_cmd(fxp_op_pkg::OP_MUL, 4'h9, 16'h7000, 16'h7000);
    send_cmd(fxp_op_pkg::OP_MUL, 4'hA, 16'h7000, 16'h9000);
    send_cmd(fxp_op_pkg::OP_MUL, 4'hB, 16'h8000, 16'h8000);
    send_cmd(fxp_op_pkg::OP_MUL, 4'hC, 16'h0180, 16'h0200);
    send_cmd(fxp_op_pkg::OP_MUL, 4'hD, 16'hFF80, 16'h0300);
    finish_test();

    start_test("pass");
    send_cmd(fxp_op_pkg::OP_PASS, 4'hE, 16'h1234, 16'h7FFF);
    send_cmd(fxp_op_pkg::OP_PASS, 4'hF, 16'h8001, 16'h8000);
    send_cmd(fxp_op_pkg::OP_PASS, 4'h0, 16'hFFFF, 16'h0001);
    finish_test();

    // Back-to-back random commands with an idle cycle now and then
    start_test("stream");
    for (int i = 0; i < 400; i++) begin
      logic [31:0] r;
      next_random(r);
      if (r[31:29] == 3'd0) begin
        send_idle();
      end
      send_random();
    end
    finish_test();

    // Reset with commands in flight, inputs keep toggling during reset
    start_test("midreset");
    repeat (10) send_random();
    for (int i = 0; i < 8; i++) begin
      send_random();
      reset = 1'b1;
    end
    @(posedge clk);
    #2;
    reset    = 1'b0;
    in_valid = 1'b0;
    repeat (19) send_random();
    finish_test();

    $display("tests run %0d, passed %0d, responses checked %0d, errors %0d",
             tests_run, tests_passed, check_count, error_count);
    if (error_count == 0 && tests_passed == tests_run) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- rtl/addfxp.sv
// Add pipeline
// Sum in the first stage, halved by every later stage

`timescale 1ns/1ps

module addfxp #(
  parameter int width  = 16,
  parameter int cycles = 1
) (
  input  logic                 clk,
  input  fxp_num_pkg::sample_t a,
  input  fxp_num_pkg::sample_t b,
  output fxp_num_pkg::sample_t q
);

  // One entry per stage
  // res[0] holds a + b, later stages shift right by one each
  logic signed [width-1:0] res [cycles];

  always_ff @(posedge clk) begin
    // Wrapped sum, carry out of the top bit is dropped
    res[0] <= a + b;
    // Logical shift per stage, same structure as the subtractor
    for (int i = 1; i < cycles; i++) begin
      res[i] <= res[i-1] >> 1;
    end
  end

  // Last stage drives the output
  assign q = res[cycles-1];

endmodule

//--- rtl/fxp_delay_line.sv
// Valid and payload delay line

`timescale 1ns/1ps

module fxp_delay_line #(
  parameter type payload_t = logic,
  parameter int  depth     = 1
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  logic     valid_r [depth];
  payload_t data_r  [depth];

  // Valid bits, cleared so in-flight commands vanish on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < depth; i++) begin
        valid_r[i] <= 1'b0;
      end
    end else begin
      valid_r[0] <= in_valid;
      for (int i = 1; i < depth; i++) begin
        valid_r[i] <= valid_r[i-1];
      end
    end
  end

  // Payload just follows, qualified by valid downstream
  always_ff @(posedge clk) begin
    data_r[0] <= in_data;
    for (int i = 1; i < depth; i++) begin
      data_r[i] <= data_r[i-1];
    end
  end

  assign out_valid = valid_r[depth-1];
  assign out_data  = data_r[depth-1];

endmodule

//--- rtl/fxp_num_pkg.sv
// Fixed-point number format
// Operand width, fraction bits and the sample type

package fxp_num_pkg;

  // Default operand width in bits
  localparam int WIDTH = 16;

  // Default number of fraction bits (Q7.8 with the defaults)
  localparam int FRAC = 8;

  // Signed fixed-point sample
  // Integer part is WIDTH-FRAC bits including sign
  typedef logic signed [WIDTH-1:0] sample_t;

endpackage

//--- rtl/fxp_op_pkg.sv
// Arithmetic unit operations
// Operation codes, command, control and response words

package fxp_op_pkg;

  // Operation codes, PASS returns a unchanged
  typedef enum logic [1:0] {
    OP_ADD  = 2'd0,
    OP_SUB  = 2'd1,
    OP_MUL  = 2'd2,
    OP_PASS = 2'd3
  } op_e;

  // Tag width, echoed back with the response
  localparam int TAG_W = 4;

  // Incoming command, 38 bits
  typedef struct packed {
    op_e                  op;
    logic [TAG_W-1:0]     tag;
    fxp_num_pkg::sample_t a;
    fxp_num_pkg::sample_t b;
  } cmd_t;

  // Control word that rides alongside the datapaths
  typedef struct packed {
    op_e              op;
    logic [TAG_W-1:0] tag;
  } ctl_t;

  // Response, 21 bits
  typedef struct packed {
    logic [TAG_W-1:0]     tag;
    fxp_num_pkg::sample_t value;
    logic                 ovf;
  } rsp_t;

endpackage

//--- rtl/fxp_result_select.sv
// Result selector
// Picks the datapath output by op, registers the response

`timescale 1ns/1ps

module fxp_result_select (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 ctl_valid,
  input  fxp_op_pkg::ctl_t     ctl,
  input  fxp_num_pkg::sample_t add_q,
  input  fxp_num_pkg::sample_t sub_q,
  input  fxp_num_pkg::sample_t mul_q,
  input  fxp_num_pkg::sample_t pass_q,
  input  logic                 mul_ovf,
  output logic                 out_valid,
  output fxp_op_pkg::rsp_t     rsp
);

  fxp_op_pkg::rsp_t rsp_d;

  // Build the next response from the aligned control word
  always_comb begin
    rsp_d.tag = ctl.tag;
    rsp_d.ovf = 1'b0;
    case (ctl.op)
      fxp_op_pkg::OP_ADD: begin
        rsp_d.value = add_q;
      end
      fxp_op_pkg::OP_SUB: begin
        rsp_d.value = sub_q;
      end
      fxp_op_pkg::OP_MUL: begin
        rsp_d.value = mul_q;
        // Only the multiplier can saturate
        rsp_d.ovf   = mul_ovf;
      end
      default: begin
        // OP_PASS
        rsp_d.value = pass_q;
      end
    endcase
  end

  // Strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= ctl_valid;
    end
  end

  // Response payload, only meaningful with out_valid
  always_ff @(posedge clk) begin
    rsp <= rsp_d;
  end

endmodule

//--- rtl/fxp_unit.sv
// Pipelined fixed-point arithmetic unit
// Add, subtract, multiply and pass with equal latency

`timescale 1ns/1ps

module fxp_unit #(
  parameter int width  = fxp_num_pkg::WIDTH,
  parameter int cycles = 1,
  parameter int frac   = fxp_num_pkg::FRAC
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_valid,
  input  fxp_op_pkg::cmd_t cmd,
  output logic             out_valid,
  output fxp_op_pkg::rsp_t rsp
);

  fxp_op_pkg::ctl_t     ctl_in;
  fxp_op_pkg::ctl_t     ctl_dly;
  logic                 valid_dly;

  fxp_num_pkg::sample_t add_q;
  fxp_num_pkg::sample_t sub_q;
  fxp_num_pkg::sample_t mul_q;
  fxp_num_pkg::sample_t pass_q;
  logic                 mul_ovf;

  // Control fields that travel with the operands
  assign ctl_in.op  = cmd.op;
  assign ctl_in.tag = cmd.tag;

  // Free-running datapaths, all cycles deep
  addfxp #(
    .width  (width),
    .cycles (cycles)
  ) u_add (
    .clk (clk),
    .a   (cmd.a),
    .b   (cmd.b),
    .q   (add_q)
  );

  subfxp #(
    .width  (width),
    .cycles (cycles)
  ) u_sub (
    .clk (clk),
    .a   (cmd.a),
    .b   (cmd.b),
    .q   (sub_q)
  );

  multfxp #(
    .width  (width),
    .cycles (cycles),
    .frac   (frac)
  ) u_mul (
    .clk (clk),
    .a   (cmd.a),
    .b   (cmd.b),
    .q   (mul_q),
    .ovf (mul_ovf)
  );

  // Valid, op and tag, aligned with the datapath outputs
  fxp_delay_line #(
    .payload_t (fxp_op_pkg::ctl_t),
    .depth     (cycles)
  ) u_ctl_dly (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_data   (ctl_in),
    .out_valid (valid_dly),
    .out_data  (ctl_dly)
  );

  // Operand a for OP_PASS
  // Its valid output duplicates the control line and stays open
  fxp_delay_line #(
    .payload_t (fxp_num_pkg::sample_t),
    .depth     (cycles)
  ) u_pass_dly (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_data   (cmd.a),
    .out_valid (),
    .out_data  (pass_q)
  );

  // One more register stage for the response
  fxp_result_select u_sel (
    .clk       (clk),
    .reset     (reset),
    .ctl_valid (valid_dly),
    .ctl       (ctl_dly),
    .add_q     (add_q),
    .sub_q     (sub_q),
    .mul_q     (mul_q),
    .pass_q    (pass_q),
    .mul_ovf   (mul_ovf),
    .out_valid (out_valid),
    .rsp       (rsp)
  );

endmodule

//--- rtl/multfxp.sv
// Q-format multiplier
// Full product, realign by frac, saturate, pad to latency

`timescale 1ns/1ps

module multfxp #(
  parameter int width  = 16,
  parameter int cycles = 1,
  parameter int frac   = 8
) (
  input  logic                 clk,
  input  fxp_num_pkg::sample_t a,
  input  fxp_num_pkg::sample_t b,
  output fxp_num_pkg::sample_t q,
  output logic                 ovf
);

  // Stages after the realign point
  // With a single cycle the realign logic sits in front of the only register
  localparam int NSAT = (cycles > 1) ? cycles - 1 : 1;

  localparam logic signed [width-1:0] SAT_MAX = {1'b0, {(width-1){1'b1}}};
  localparam logic signed [width-1:0] SAT_MIN = {1'b1, {(width-1){1'b0}}};

  logic signed [2*width-1:0] prod_d;
  logic signed [2*width-1:0] prod_sel;
  logic signed [2*width-1:0] shifted;
  logic [width:0]            upper;
  logic                      fits;
  logic signed [width-1:0]   sat_val;
  logic                      sat_ovf;

  logic signed [width-1:0]   val_r [NSAT];
  logic                      ovf_r [NSAT];

  // Signed operands extend to the full product width
  assign prod_d = a * b;

  generate
    if (cycles > 1) begin : g_prod_reg
      logic signed [2*width-1:0] prod_q;
      // First stage holds the raw product
      always_ff @(posedge clk) begin
        prod_q <= prod_d;
      end
      assign prod_sel = prod_q;
    end else begin : g_prod_comb
      assign prod_sel = prod_d;
    end
  endgenerate

  // Drop the extra fraction bits, truncating toward minus infinity
  assign shifted = prod_sel >>> frac;

  // Upper bits must all match the result sign bit
  assign upper = shifted[2*width-1:width-1];
  assign fits  = (&upper) | ~(|upper);

  // Clamp toward the sign of the full value
  assign sat_val = fits ? shifted[width-1:0] : (shifted[2*width-1] ? SAT_MIN : SAT_MAX);
  assign sat_ovf = ~fits;

  always_ff @(posedge clk) begin
    val_r[0] <= sat_val;
    ovf_r[0] <= sat_ovf;
    // Padding stages keep flag and value aligned
    for (int i = 1; i < NSAT; i++) begin
      val_r[i] <= val_r[i-1];
      ovf_r[i] <= ovf_r[i-1];
    end
  end

  assign q   = val_r[NSAT-1];
  assign ovf = ovf_r[NSAT-1];

endmodule

//--- rtl/subfxp.sv
// Subtract pipeline
// Difference in the first stage, halved by every later stage

`timescale 1ns/1ps

module subfxp #(
  parameter int width  = 16,
  parameter int cycles = 1
) (
  input  logic                 clk,
  input  fxp_num_pkg::sample_t a,
  input  fxp_num_pkg::sample_t b,
  output fxp_num_pkg::sample_t q
);

  // One entry per stage
  // res[0] holds a - b, res[i] holds res[i-1] shifted right by one
  logic signed [width-1:0] res [cycles];

  always_ff @(posedge clk) begin
    // Wrapped difference, no saturation
    res[0] <= a - b;
    // Logical shift, sign bit is not replicated
    for (int i = 1; i < cycles; i++) begin
      res[i] <= res[i-1] >> 1;
    end
  end

  // Output is the last stage
  // Net effect is (a - b) >> (cycles - 1)
  assign q = res[cycles-1];

endmodule

//--- sim.f
rtl/fxp_num_pkg.sv
rtl/fxp_op_pkg.sv
rtl/subfxp.sv
rtl/addfxp.sv
rtl/multfxp.sv
rtl/fxp_delay_line.sv
rtl/fxp_result_select.sv
rtl/fxp_unit.sv
dv/fxp_unit_checker.sv
dv/fxp_unit_tb.sv
